/* Makefile */
# Verilator build and run of the hdc_item testbench

VERILATOR ?= verilator
SIM_TOP   ?= tb_hdc_item_top
FILELIST  ?= hdc_item.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_hdc_item_top.sv */
`timescale 1ns/1ns

module tb_hdc_item_top;
    import hdc_pkg::*;

    localparam int DIM   = 64;
    localparam int WORDS = DIM / 32;

    // byte addresses of the register map
    localparam logic [31:0] ADDR_CTRL       = 32'h0000_0000;
    localparam logic [31:0] ADDR_ITEM_COUNT = 32'h0000_0004;
    localparam logic [31:0] ADDR_VEC        = 32'h0000_0008;

    localparam int NUM_RUNS       = 40;
    // one poll read takes at most about 12 cycles
    // and a poll may just miss the clear
    localparam int POLL_SLACK     = 24;
    localparam int RUN_MAX_CYCLES = 1024 * WORDS + 50;
    localparam int BUS_OVERHEAD   = 4000;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_MAX_CYCLES + BUS_OVERHEAD;

    logic        AXIS_ACLK;
    logic        S_AXI_ARESETN;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [1:0]  s_axi_bresp;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;

    integer seed;
    int     cycle_cnt = 0;
    int     err_cnt = 0;
    int     check_cnt = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    string  cur_test = "none";

    hdc_item_top #(
        .DIM (DIM)
    ) hdc_item_top_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp)
    );

    // 10 ns clock
    always #5 AXIS_ACLK = ~AXIS_ACLK;

    always @(posedge AXIS_ACLK) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    // xorshift32 with shifts 13, 17, 5
    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // item n = x(n*WORDS) .. x(n*WORDS+WORDS-1)
    // word k in bits 32k+31..32k
    function automatic logic [DIM-1:0] model_item(input int n);
        logic [31:0]    x;
        logic [DIM-1:0] v;
        int             i;
        x = XORSHIFT_SEED;
        for (i = 0; i < n * WORDS; i++) begin
            x = xorshift_step(x);
        end
        for (i = 0; i < WORDS; i++) begin
            v[32*i +: 32] = x;
            x = xorshift_step(x);
        end
        return v;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // --------------------------------------------------
    // checks and reporting
    // --------------------------------------------------

    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] got);
        check_cnt++;
        assert (got === exp) else begin
            $display("[ERROR] %s (%s): expected 0x%08h, actual 0x%08h",
                     cur_test, what, exp, got);
            err_cnt++;
        end
    endtask

    task automatic report_test(input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", cur_test, err_cnt - errs_before);
        end
    endtask

    // --------------------------------------------------
    // AXI-Lite master tasks
    // --------------------------------------------------

    // drive on the rising edge and look at handshakes on the falling edge
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        int unsigned aw_wait;
        int unsigned w_wait;
        int unsigned b_wait;
        int unsigned cyc;
        bit          aw_done;
        bit          w_done;
        bit          b_done;
        aw_wait = rand_below(4);
        w_wait  = rand_below(4);
        b_wait  = rand_below(4);
        aw_done = 1'b0;
        w_done  = 1'b0;
        b_done  = 1'b0;
        cyc     = 0;
        // address and data together or in either order
        while (!(aw_done && w_done)) begin
            @(posedge AXIS_ACLK);
            s_axi_awaddr  <= addr;
            s_axi_wdata   <= data;
            s_axi_awvalid <= !aw_done && (cyc >= aw_wait);
            s_axi_wvalid  <= !w_done && (cyc >= w_wait);
            @(negedge AXIS_ACLK);
            if (s_axi_awvalid && s_axi_awready) begin
                aw_done = 1'b1;
            end
            if (s_axi_wvalid && s_axi_wready) begin
                w_done = 1'b1;
            end
            cyc++;
        end
        cyc = 0;
        // response with a random bready delay
        while (!b_done) begin
            @(posedge AXIS_ACLK);
            s_axi_awvalid <= 1'b0;
            s_axi_wvalid  <= 1'b0;
            s_axi_bready  <= (cyc >= b_wait);
            @(negedge AXIS_ACLK);
            if (s_axi_bvalid && s_axi_bready) begin
                b_done = 1'b1;
                compare_word("bresp", 32'd0, {30'd0, s_axi_bresp});
            end
            cyc++;
        end
        @(posedge AXIS_ACLK);
        s_axi_bready <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, input int unsigned max_rwait,
                            output logic [31:0] data);
        int unsigned ar_wait;
        int unsigned r_wait;
        int unsigned cyc;
        bit          ar_done;
        bit          r_done;
        ar_wait = rand_below(4);
        r_wait  = rand_below(max_rwait + 1);
        ar_done = 1'b0;
        r_done  = 1'b0;
        cyc     = 0;
        while (!ar_done) begin
            @(posedge AXIS_ACLK);
            s_axi_araddr  <= addr;
            s_axi_arvalid <= (cyc >= ar_wait);
            @(negedge AXIS_ACLK);
            if (s_axi_arvalid && s_axi_arready) begin
                ar_done = 1'b1;
            end
            cyc++;
        end
        cyc = 0;
        // rready back-pressure
        while (!r_done) begin
            @(posedge AXIS_ACLK);
            s_axi_arvalid <= 1'b0;
            s_axi_rready  <= (cyc >= r_wait);
            @(negedge AXIS_ACLK);
            if (s_axi_rvalid && s_axi_rready) begin
                r_done = 1'b1;
                data   = s_axi_rdata;
                compare_word("rresp", 32'd0, {30'd0, s_axi_rresp});
            end
            cyc++;
        end
        @(posedge AXIS_ACLK);
        s_axi_rready <= 1'b0;
    endtask

    // --------------------------------------------------
    // generation helpers
    // --------------------------------------------------

    task automatic start_run(input int n);
        bus_write(ADDR_ITEM_COUNT, n);
        bus_write(ADDR_CTRL, 32'd1);
    endtask

    // poll ctrl until gen drops or the run length runs out
    task automatic wait_gen_clear(input int n);
        logic [31:0] val;
        int          start;
        int          limit;
        bit          busy;
        limit = (n + 1) * WORDS + POLL_SLACK;
        start = cycle_cnt;
        busy  = 1'b1;
        while (busy && (cycle_cnt - start) <= limit) begin
            bus_read(ADDR_CTRL, 3, val);
            if (val[0] == 1'b0) begin
                busy = 1'b0;
                compare_word("ctrl after done", 32'd0, val);
            end
        end
        check_cnt++;
        assert (!busy) else begin
            $display("%s: gen still set after %0d cycles, limit was %0d cycles",
                     cur_test, cycle_cnt - start, limit);
            err_cnt++;
        end
    endtask

    task automatic check_vector(input int n, input int unsigned max_rwait);
        logic [DIM-1:0] exp;
        logic [31:0]    got;
        int             k;
        exp = model_item(n);
        for (k = 0; k < WORDS; k++) begin
            bus_read(ADDR_VEC + 4 * k, max_rwait, got);
            compare_word($sformatf("item %0d word %0d", n, k), exp[32*k +: 32], got);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------

    initial begin : main
        logic [31:0] val;
        logic [31:0] data;
        logic [31:0] cur_count;
        int          errs;
        int          n;
        int          i;
        seed            = 47937;
        AXIS_ACLK       = 1'b0;
        S_AXI_ARESETN  <= 1'b0;
        s_axi_awaddr   <= '0;
        s_axi_awvalid  <= 1'b0;
        s_axi_wdata    <= '0;
        s_axi_wvalid   <= 1'b0;
        s_axi_bready   <= 1'b0;
        s_axi_araddr   <= '0;
        s_axi_arvalid  <= 1'b0;
        s_axi_rready   <= 1'b0;
        repeat (16) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(posedge AXIS_ACLK);

        // registers come out of reset cleared
        cur_test = "reset_values";
        errs = err_cnt;
        // awready wready arready high, bvalid rvalid low
        @(negedge AXIS_ACLK);
        compare_word("idle handshake levels", 32'h0000_001c,
                     {27'd0, s_axi_awready, s_axi_wready, s_axi_arready,
                      s_axi_bvalid, s_axi_rvalid});
        bus_read(ADDR_CTRL, 3, val);
        compare_word("ctrl", 32'd0, val);
        bus_read(ADDR_ITEM_COUNT, 3, val);
        compare_word("item_count", 32'd0, val);
        report_test(errs);

        // only the low 10 bits are kept
        cur_test = "item_count_rw";
        errs = err_cnt;
        for (i = 0; i < 8; i++) begin
            data = $random(seed);
            bus_write(ADDR_ITEM_COUNT, data);
            bus_read(ADDR_ITEM_COUNT, 3, val);
            compare_word("readback", {22'd0, data[9:0]}, val);
        end
        report_test(errs);

        cur_test = "gen_done";
        errs = err_cnt;
        n = rand_below(1024);
        start_run(n);
        wait_gen_clear(n);
        report_test(errs);

        cur_test = "vector_match";
        errs = err_cnt;
        check_vector(n, 0);
        report_test(errs);

        // heavier rready stalls, unmapped indices, bits 11..10 set
        cur_test = "readback_rules";
        errs = err_cnt;
        check_vector(n, 7);
        for (i = 0; i < 6; i++) begin
            bus_read(4 * (WORDS + 2 + rand_below(256 - (WORDS + 2))), 5, val);
            compare_word("unmapped index", 32'd0, val);
            bus_read(((1 + rand_below(3)) << 10) | (4 * rand_below(WORDS + 2)), 5, val);
            compare_word("outside window", 32'd0, val);
        end
        // a write outside the window must not reach item_count
        cur_count = n;
        bus_write(32'h0000_0400 | ADDR_ITEM_COUNT, $random(seed));
        bus_read(ADDR_ITEM_COUNT, 3, val);
        compare_word("window write ignored", cur_count, val);
        report_test(errs);

        // every run restarts from the seed
        for (i = 1; i < NUM_RUNS; i++) begin
            cur_test = $sformatf("rerun_%0d", i);
            errs = err_cnt;
            n = rand_below(1024);
            start_run(n);
            wait_gen_clear(n);
            check_vector(n, 3);
            report_test(errs);
        end

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog over the whole run
    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* hdc_item.f */
verilog/hdc_pkg.sv
verilog/xorshift_prng.sv
verilog/item_vector_gen.sv
verilog/axil_slave.sv
verilog/ctrl_regs.sv
verilog/hdc_item_top.sv
dv/tb_hdc_item_top.sv

/* verilog/axil_slave.sv */
`timescale 1ns/1ns

module axil_slave (
    input  logic             AXIS_ACLK,
    input  logic             S_AXI_ARESETN,
    input  logic [31:0]      s_axi_awaddr,
    input  logic             s_axi_awvalid,
    output logic             s_axi_awready,
    input  logic [31:0]      s_axi_wdata,
    input  logic             s_axi_wvalid,
    output logic             s_axi_wready,
    output logic             s_axi_bvalid,
    input  logic             s_axi_bready,
    input  logic [31:0]      s_axi_araddr,
    input  logic             s_axi_arvalid,
    output logic             s_axi_arready,
    output logic             s_axi_rvalid,
    input  logic             s_axi_rready,
    output hdc_pkg::reg_wr_t wr,
    output hdc_pkg::reg_rd_t rd
);
    import hdc_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AW,
        ST_W,
        ST_BRESP,
        ST_RWAIT,
        ST_RRESP
    } state_t;

    state_t               state;
    logic                 resp_first;
    logic [REG_IDX_W+1:0] addr_q;
    logic [31:0]          data_q;
    logic                 in_window;

    // --------------------------------------------------
    // handshakes
    // --------------------------------------------------

    assign s_axi_awready = (state == ST_IDLE) | (state == ST_W);
    assign s_axi_wready  = (state == ST_IDLE) | (state == ST_AW);
    // writes win over a read offered in the same cycle
    assign s_axi_arready = (state == ST_IDLE) & ~s_axi_awvalid & ~s_axi_wvalid;
    assign s_axi_bvalid  = (state == ST_BRESP);
    assign s_axi_rvalid  = (state == ST_RRESP);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state      <= ST_IDLE;
            resp_first <= 1'b0;
        end else begin
            resp_first <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state      <= ST_BRESP;
                        resp_first <= 1'b1;
                    end else if (s_axi_awvalid) begin
                        state <= ST_AW;
                    end else if (s_axi_wvalid) begin
                        state <= ST_W;
                    end else if (s_axi_arvalid) begin
                        state <= ST_RWAIT;
                    end
                end
                ST_AW: begin
                    if (s_axi_wvalid) begin
                        state      <= ST_BRESP;
                        resp_first <= 1'b1;
                    end
                end
                ST_W: begin
                    if (s_axi_awvalid) begin
                        state      <= ST_BRESP;
                        resp_first <= 1'b1;
                    end
                end
                ST_BRESP: begin
                    if (s_axi_bready) begin
                        state <= ST_IDLE;
                    end
                end
                // register file samples the read here
                ST_RWAIT: begin
                    state <= ST_RRESP;
                end
                ST_RRESP: begin
                    if (s_axi_rready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // address bits 11..2 of either channel, write data
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            addr_q <= s_axi_awaddr[11:2];
        end else if (s_axi_arvalid && s_axi_arready) begin
            addr_q <= s_axi_araddr[11:2];
        end
        if (s_axi_wvalid && s_axi_wready) begin
            data_q <= s_axi_wdata;
        end
    end

    // --------------------------------------------------
    // register strobes
    // --------------------------------------------------

    // bits 11..10 must be zero
    assign in_window = (addr_q[REG_IDX_W+1:REG_IDX_W] == 2'b00);

    always_comb begin
        wr.valid = resp_first & in_window;
        wr.idx   = addr_q[REG_IDX_W-1:0];
        wr.data  = data_q;
    end

    // outside the window the read lands on an unmapped index and returns zero
    always_comb begin
        rd.valid = (state == ST_RWAIT);
        rd.idx   = in_window ? addr_q[REG_IDX_W-1:0] : '1;
    end

endmodule

/* verilog/ctrl_regs.sv */
`timescale 1ns/1ns

module ctrl_regs #(
    parameter int DIM = 32
) (
    input  logic               AXIS_ACLK,
    input  logic               S_AXI_ARESETN,
    input  hdc_pkg::reg_wr_t   wr,
    input  hdc_pkg::reg_rd_t   rd,
    input  logic               done,
    input  logic [DIM-1:0]     item_vec,
    output hdc_pkg::gen_ctrl_t ctrl,
    output logic [31:0]        rdata
);
    import hdc_pkg::*;

    localparam int WORDS = DIM / 32;

    logic                 gen;
    logic [ITEM_W-1:0]    item_count;
    logic [REG_IDX_W-1:0] vec_sel;
    logic [31:0]          rd_word;

    // --------------------------------------------------
    // write decode
    // --------------------------------------------------

    // a write to ctrl beats the auto-clear in the same cycle
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen <= 1'b0;
        end else if (wr.valid && wr.idx == REG_CTRL) begin
            gen <= wr.data[0];
        end else if (done) begin
            gen <= 1'b0;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            item_count <= '0;
        end else if (wr.valid && wr.idx == REG_ITEM_COUNT) begin
            item_count <= wr.data[ITEM_W-1:0];
        end
    end

    always_comb begin
        ctrl.gen        = gen;
        ctrl.item_count = item_count;
    end

    // --------------------------------------------------
    // read mux
    // --------------------------------------------------

    assign vec_sel = rd.idx - REG_VEC_BASE;

    // unused bits and unmapped indices read zero
    always_comb begin
        rd_word = '0;
        if (rd.idx == REG_CTRL) begin
            rd_word[0] = gen;
        end else if (rd.idx == REG_ITEM_COUNT) begin
            rd_word[ITEM_W-1:0] = item_count;
        end else if (rd.idx >= REG_VEC_BASE && vec_sel < WORDS) begin
            rd_word = item_vec[32*vec_sel +: 32];
        end
    end

    // held through the read response
    always_ff @(posedge AXIS_ACLK) begin
        if (rd.valid) begin
            rdata <= rd_word;
        end
    end

endmodule

/* verilog/hdc_item_top.sv */
`timescale 1ns/1ns

module hdc_item_top #(
    parameter int DIM = 32
) (
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic [31:0] s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    input  logic [31:0] s_axi_wdata,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    output logic [1:0]  s_axi_bresp,
    input  logic [31:0] s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,
    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp
);
    import hdc_pkg::*;

    reg_wr_t        wr;
    reg_rd_t        rd;
    gen_ctrl_t      ctrl;
    logic           done;
    logic [DIM-1:0] item_vec;

    // every transfer completes with okay
    assign s_axi_bresp = AXI_RESP_OKAY;
    assign s_axi_rresp = AXI_RESP_OKAY;

    // --------------------------------------------------
    // bus slave -> register file -> generator
    // --------------------------------------------------

    axil_slave axil_slave_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr            (wr),
        .rd            (rd)
    );

    ctrl_regs #(
        .DIM (DIM)
    ) ctrl_regs_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr            (wr),
        .rd            (rd),
        .done          (done),
        .item_vec      (item_vec),
        .ctrl          (ctrl),
        .rdata         (s_axi_rdata)
    );

    item_vector_gen #(
        .DIM (DIM)
    ) item_vector_gen_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (ctrl),
        .done          (done),
        .item_vec      (item_vec)
    );

endmodule

/* verilog/hdc_pkg.sv */
package hdc_pkg;

    // --------------------------------------------------
    // xorshift32 generator
    // --------------------------------------------------

    // start state, also reloaded whenever gen is low
    localparam logic [31:0] XORSHIFT_SEED = 32'd2463534242;

    // shift amounts of one step: x ^= x << a, x ^= x >> b, x ^= x << c
    localparam int unsigned XORSHIFT_SHL_A = 13;
    localparam int unsigned XORSHIFT_SHR_B = 17;
    localparam int unsigned XORSHIFT_SHL_C = 5;

    // --------------------------------------------------
    // register map
    // --------------------------------------------------

    // word index taken from address bits 9..2
    localparam int REG_IDX_W = 8;

    // 0x00 ctrl, 0x04 item count, vector words from 0x08
    localparam logic [REG_IDX_W-1:0] REG_CTRL       = 8'd0;
    localparam logic [REG_IDX_W-1:0] REG_ITEM_COUNT = 8'd1;
    localparam logic [REG_IDX_W-1:0] REG_VEC_BASE   = 8'd2;

    // item counters, up to 1024 items
    localparam int ITEM_W = 10;

    // bresp / rresp
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // --------------------------------------------------
    // strobes and levels between blocks
    // --------------------------------------------------

    // register write, one cycle
    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] idx;
        logic [31:0]          data;
    } reg_wr_t;

    // register read, one cycle
    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] idx;
    } reg_rd_t;

    // control level to the generator
    typedef struct packed {
        logic              gen;
        logic [ITEM_W-1:0] item_count;
    } gen_ctrl_t;

endpackage

/* verilog/item_vector_gen.sv */
`timescale 1ns/1ns

module item_vector_gen #(
    parameter int DIM = 32
) (
    input  logic              AXIS_ACLK,
    input  logic              S_AXI_ARESETN,
    input  hdc_pkg::gen_ctrl_t ctrl,
    output logic              done,
    output logic [DIM-1:0]    item_vec
);
    import hdc_pkg::*;

    localparam int WORDS  = DIM / 32;
    localparam int WCNT_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [31:0]       rand_num;
    logic [WCNT_W-1:0] word_cnt;
    logic              last_word;
    logic              update_item;
    logic [ITEM_W-1:0] item_cnt;
    logic [DIM-1:0]    assembly;
    logic              hit;

    xorshift_prng prng_inst (
        .AXIS_ACLK (AXIS_ACLK),
        .gen       (ctrl.gen),
        .rand_num  (rand_num)
    );

    // --------------------------------------------------
    // word and item counters
    // --------------------------------------------------

    assign last_word = (word_cnt == WCNT_W'(WORDS - 1));

    // slot of the current generator word
    always_ff @(posedge AXIS_ACLK) begin
        if (!ctrl.gen || last_word) begin
            word_cnt <= '0;
        end else begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // high in the cycle after the last word of an item
    always_ff @(posedge AXIS_ACLK) begin
        if (!ctrl.gen) begin
            update_item <= 1'b0;
        end else begin
            update_item <= last_word;
        end
    end

    // number of the item sitting complete in the assembly register
    always_ff @(posedge AXIS_ACLK) begin
        if (!ctrl.gen) begin
            item_cnt <= '0;
        end else if (update_item) begin
            item_cnt <= item_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // assembly and capture
    // --------------------------------------------------

    // word k lands in bits 32k+31..32k
    always_ff @(posedge AXIS_ACLK) begin
        if (ctrl.gen) begin
            assembly[32*word_cnt +: 32] <= rand_num;
        end
    end

    // requested item complete
    assign hit  = ctrl.gen & update_item & (item_cnt == ctrl.item_count);
    assign done = hit;

    // last capture stays readable after gen drops
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            item_vec <= '0;
        end else if (hit) begin
            item_vec <= assembly;
        end
    end

endmodule

/* verilog/xorshift_prng.sv */
`timescale 1ns/1ns

module xorshift_prng (
    input  logic        AXIS_ACLK,
    input  logic        gen,
    output logic [31:0] rand_num
);
    import hdc_pkg::*;

    logic [31:0] state;
    logic [31:0] state_next;

    // one xorshift32 step
    always_comb begin
        logic [31:0] x;
        x = state;
        x = x ^ (x << XORSHIFT_SHL_A);
        x = x ^ (x >> XORSHIFT_SHR_B);
        x = x ^ (x << XORSHIFT_SHL_C);
        state_next = x;
    end

    // held at the seed while idle, so every run restarts the sequence
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            state <= XORSHIFT_SEED;
        end else begin
            state <= state_next;
        end
    end

    assign rand_num = state;

endmodule
